// ==== hdl/readout_macros.svh ====
`ifndef READOUT_MACROS_SVH
`define READOUT_MACROS_SVH

// number of front-end links feeding completions
`define READOUT_NUM_LINKS 4

// low word offset of every event buffer in memory
`define READOUT_START_OFFSET 18'h03E00

// 64-bit words read per event
`define READOUT_BURST_WORDS 8

// entries in the reader output FIFO
`define READOUT_FIFO_DEPTH 16

`endif

// ==== hdl/readout_pkg.sv ====
package readout_pkg;

    // header from the event builder
    typedef struct packed {
        logic [2:0]  unused;
        logic [12:0] upper_addr;
        logic [7:0]  err;
    } hdr_word_t;

    // completion from one front-end link, nonzero err means failure
    typedef struct packed {
        logic [15:0] info;
        logic [15:0] err;
    } cmpl_word_t;

    typedef logic [1:0] link_idx_t;

    // announces an event downstream
    typedef struct packed {
        logic [11:0] upper_addr;
        logic        pad;
        logic [18:0] byte_count;
    } ctrl_word_t;

    typedef enum logic [1:0] {IDLE, ISSUE_CMD, ISSUE_CONTROL, WAIT_DONE} seq_state_e;

endpackage

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // word address, upper address sits above the 18-bit offset
    typedef logic [30:0] mem_addr_t;

    typedef logic [63:0] mem_data_t;

    typedef logic [7:0] burst_len_t;

    // one burst read request
    typedef struct packed {
        mem_addr_t  base;
        burst_len_t words;
    } burst_cmd_t;

endpackage

// ==== hdl/readout_if.sv ====
// one pending completion per link, seen by the sequencer
interface lane_if;
    logic                   pending;
    readout_pkg::cmpl_word_t word;
    logic                   err;
    logic                   take;

    modport lane (
        output pending,
        output word,
        output err,
        input  take
    );

    modport seq (
        input  pending,
        input  word,
        input  err,
        output take
    );
endinterface

// burst request from sequencer to reader
interface burst_cmd_if;
    logic                cmd_valid;
    logic                cmd_ready;
    mem_pkg::burst_cmd_t cmd;
    logic                done;

    modport host (
        output cmd_valid,
        output cmd,
        input  cmd_ready,
        input  done
    );

    modport target (
        input  cmd_valid,
        input  cmd,
        output cmd_ready,
        output done
    );
endinterface

// ==== hdl/completion_router.sv ====
`include "readout_macros.svh"

module completion_router (
    input  logic                                aclk,
    input  logic                                memresetn,
    input  logic                                cmpl_valid,
    output logic                                cmpl_ready,
    input  readout_pkg::link_idx_t              cmpl_link,
    input  readout_pkg::cmpl_word_t             cmpl_data,
    output logic [`READOUT_NUM_LINKS-1:0]       lane_valid,
    input  logic [`READOUT_NUM_LINKS-1:0]       lane_ready,
    output readout_pkg::cmpl_word_t             lane_word
);

    // one-hot valid toward the addressed lane only
    always_comb begin
        lane_valid = '0;
        lane_valid[cmpl_link] = cmpl_valid;
    end

    // stream stalls while the addressed lane is still full
    assign cmpl_ready = lane_ready[cmpl_link];

    // every lane sees the same word, only the addressed one loads it
    assign lane_word = cmpl_data;

    // tag must name an existing link
    assert property (@(posedge aclk) disable iff (!memresetn)
        cmpl_valid |-> (int'(cmpl_link) < `READOUT_NUM_LINKS));

endmodule

// ==== hdl/completion_lane.sv ====
module completion_lane (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  readout_pkg::cmpl_word_t in_word,
    lane_if.lane                    lane
);

    logic                    pending_q;
    logic                    err_q;
    readout_pkg::cmpl_word_t word_q;
    logic                    load;

    assign load = in_valid && in_ready;

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            pending_q <= 1'b0;
            in_ready  <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            if (lane.take) begin
                pending_q <= 1'b0;
                in_ready  <= 1'b1;
            end else if (load) begin
                pending_q <= 1'b1;
                in_ready  <= 1'b0;
            end else begin
                in_ready <= !pending_q;
            end
            // sticky until reset
            if (load && (in_word.err != '0)) begin
                err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            word_q <= in_word;
        end
    end

    assign lane.pending = pending_q;
    assign lane.word    = word_q;
    assign lane.err     = err_q;

    // sequencer only takes a lane that holds a word
    assert property (@(posedge aclk) disable iff (!memresetn)
        lane.take |-> pending_q);

endmodule

// ==== hdl/readout_sequencer.sv ====
`include "readout_macros.svh"

module readout_sequencer (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  readout_pkg::hdr_word_t  hdr_data,
    lane_if.seq                     lanes [`READOUT_NUM_LINKS],
    output logic                    ctrl_valid,
    input  logic                    ctrl_ready,
    output readout_pkg::ctrl_word_t ctrl_data,
    burst_cmd_if.host               burst,
    output logic                    any_err
);

    readout_pkg::seq_state_e         state;
    logic [`READOUT_NUM_LINKS-1:0]   lane_pending;
    logic [`READOUT_NUM_LINKS-1:0]   lane_err;
    logic                            accept;
    logic                            done_seen;
    logic                            hdr_err_q;
    logic [12:0]                     upper_addr_q;

    for (genvar i = 0; i < `READOUT_NUM_LINKS; i++) begin : g_lane
        assign lane_pending[i] = lanes[i].pending;
        assign lane_err[i]     = lanes[i].err;
        assign lanes[i].take   = accept;

        // a bad word being taken must already show in the lane's sticky error
        assert property (@(posedge aclk) disable iff (!memresetn)
            (lanes[i].take && (lanes[i].word.err != '0)) |-> lanes[i].err);
    end

    // header and every link present, all consumed together
    assign accept    = (state == readout_pkg::IDLE) && hdr_valid && (&lane_pending);
    assign hdr_ready = accept;

    assign burst.cmd_valid = (state == readout_pkg::ISSUE_CMD);
    assign burst.cmd.base  = {upper_addr_q, `READOUT_START_OFFSET};
    assign burst.cmd.words = mem_pkg::burst_len_t'(`READOUT_BURST_WORDS);

    assign ctrl_valid           = (state == readout_pkg::ISSUE_CONTROL);
    assign ctrl_data.upper_addr = upper_addr_q[11:0];
    assign ctrl_data.pad        = 1'b0;
    assign ctrl_data.byte_count = 19'(`READOUT_BURST_WORDS * 8);

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            state     <= readout_pkg::IDLE;
            done_seen <= 1'b0;
            hdr_err_q <= 1'b0;
            any_err   <= 1'b0;
        end else begin
            case (state)
                readout_pkg::IDLE:
                    if (accept) state <= readout_pkg::ISSUE_CMD;
                readout_pkg::ISSUE_CMD:
                    if (burst.cmd_ready) state <= readout_pkg::ISSUE_CONTROL;
                readout_pkg::ISSUE_CONTROL:
                    if (ctrl_ready) state <= readout_pkg::WAIT_DONE;
                readout_pkg::WAIT_DONE:
                    if (done_seen || burst.done) state <= readout_pkg::IDLE;
                default:
                    state <= readout_pkg::IDLE;
            endcase
            // the burst can finish while the control word is still stalled
            if (state == readout_pkg::WAIT_DONE) begin
                done_seen <= 1'b0;
            end else if (burst.done) begin
                done_seen <= 1'b1;
            end
            if (accept && (hdr_data.err != '0)) begin
                hdr_err_q <= 1'b1;
            end
            any_err <= any_err || hdr_err_q || (|lane_err);
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            upper_addr_q <= hdr_data.upper_addr;
        end
    end

    assert property (@(posedge aclk) disable iff (!memresetn)
        hdr_ready |-> (state == readout_pkg::IDLE));

    // reader finishes only bursts that belong to an event in flight
    assert property (@(posedge aclk) disable iff (!memresetn)
        burst.done |-> (state != readout_pkg::IDLE));

endmodule

// ==== hdl/event_reader.sv ====
`include "readout_macros.svh"

module event_reader (
    input  logic               aclk,
    input  logic               memresetn,
    burst_cmd_if.target        burst,
    output logic               mem_rd,
    output mem_pkg::mem_addr_t mem_addr,
    input  logic               mem_rvalid,
    input  mem_pkg::mem_data_t mem_rdata,
    output logic               data_valid,
    input  logic               data_ready,
    output logic               data_last,
    output mem_pkg::mem_data_t data_data
);

    localparam int CNT_W = $clog2(`READOUT_BURST_WORDS + 1);
    localparam int PTR_W = $clog2(`READOUT_FIFO_DEPTH);
    localparam int OCC_W = $clog2(`READOUT_FIFO_DEPTH + 1);

    logic               busy;
    logic               done_q;
    logic [CNT_W-1:0]   words_q;
    logic [CNT_W-1:0]   issued;
    logic [CNT_W-1:0]   returned;
    logic [CNT_W-1:0]   outstanding;
    mem_pkg::mem_addr_t base_q;
    logic               last_ret;
    logic               room;

    // fifo entry is {last, data}
    logic [64:0]        fifo_mem [`READOUT_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [OCC_W-1:0]   fifo_count;
    logic               pop;

    assign burst.cmd_ready = !busy;
    assign burst.done      = done_q;

    // reserve a slot for every read still in flight
    assign outstanding = issued - returned;
    assign room        = (int'(fifo_count) + int'(outstanding)) < `READOUT_FIFO_DEPTH;
    assign mem_rd      = busy && (issued != words_q) && room;
    assign mem_addr    = base_q + mem_pkg::mem_addr_t'(issued);
    assign last_ret    = (returned == words_q - 1'b1);

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            busy     <= 1'b0;
            done_q   <= 1'b0;
            issued   <= '0;
            returned <= '0;
        end else begin
            done_q <= 1'b0;
            if (burst.cmd_valid && !busy) begin
                busy     <= 1'b1;
                issued   <= '0;
                returned <= '0;
            end else begin
                if (mem_rd) issued <= issued + 1'b1;
                if (mem_rvalid) begin
                    returned <= returned + 1'b1;
                    if (last_ret) begin
                        busy   <= 1'b0;
                        done_q <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (burst.cmd_valid && !busy) begin
            base_q  <= burst.cmd.base;
            words_q <= CNT_W'(burst.cmd.words);
        end
    end

    assign pop        = data_valid && data_ready;
    assign data_valid = (fifo_count != '0);
    assign data_data  = fifo_mem[rd_ptr][63:0];
    assign data_last  = fifo_mem[rd_ptr][64];

    always_ff @(posedge aclk) begin
        if (!memresetn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (mem_rvalid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            fifo_count <= fifo_count + OCC_W'(mem_rvalid) - OCC_W'(pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (mem_rvalid) begin
            fifo_mem[wr_ptr] <= {last_ret, mem_rdata};
        end
    end

    // strobe gating a cycle earlier must leave space for every return
    assert property (@(posedge aclk) disable iff (!memresetn)
        mem_rvalid |-> (int'(fifo_count) < `READOUT_FIFO_DEPTH));

endmodule

// ==== hdl/event_readout_top.sv ====
`include "readout_macros.svh"

module event_readout_top (
    input  logic                    aclk,
    input  logic                    memresetn,
    input  logic                    cmpl_valid,
    output logic                    cmpl_ready,
    input  readout_pkg::link_idx_t  cmpl_link,
    input  readout_pkg::cmpl_word_t cmpl_data,
    input  logic                    hdr_valid,
    output logic                    hdr_ready,
    input  readout_pkg::hdr_word_t  hdr_data,
    output logic                    ctrl_valid,
    input  logic                    ctrl_ready,
    output readout_pkg::ctrl_word_t ctrl_data,
    output logic                    mem_rd,
    output mem_pkg::mem_addr_t      mem_addr,
    input  logic                    mem_rvalid,
    input  mem_pkg::mem_data_t      mem_rdata,
    output logic                    data_valid,
    input  logic                    data_ready,
    output logic                    data_last,
    output mem_pkg::mem_data_t      data_data,
    output logic                    any_err
);

    logic [`READOUT_NUM_LINKS-1:0] lane_valid;
    logic [`READOUT_NUM_LINKS-1:0] lane_ready;
    readout_pkg::cmpl_word_t       lane_word;

    lane_if      lane_bus [`READOUT_NUM_LINKS] ();
    burst_cmd_if burst_bus ();

    completion_router completion_router_i (
        .aclk       (aclk),
        .memresetn  (memresetn),
        .cmpl_valid (cmpl_valid),
        .cmpl_ready (cmpl_ready),
        .cmpl_link  (cmpl_link),
        .cmpl_data  (cmpl_data),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .lane_word  (lane_word)
    );

    for (genvar i = 0; i < `READOUT_NUM_LINKS; i++) begin : g_lane
        completion_lane completion_lane_i (
            .aclk      (aclk),
            .memresetn (memresetn),
            .in_valid  (lane_valid[i]),
            .in_ready  (lane_ready[i]),
            .in_word   (lane_word),
            .lane      (lane_bus[i])
        );
    end

    readout_sequencer readout_sequencer_i (
        .aclk       (aclk),
        .memresetn  (memresetn),
        .hdr_valid  (hdr_valid),
        .hdr_ready  (hdr_ready),
        .hdr_data   (hdr_data),
        .lanes      (lane_bus),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready),
        .ctrl_data  (ctrl_data),
        .burst      (burst_bus),
        .any_err    (any_err)
    );

    event_reader event_reader_i (
        .aclk       (aclk),
        .memresetn  (memresetn),
        .burst      (burst_bus),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data_last  (data_last),
        .data_data  (data_data)
    );

endmodule

// ==== tb/event_readout_tb.sv ====
`include "readout_macros.svh"

module event_readout_tb;

    localparam int NUM_ROWS = 7;
    localparam int TIMEOUT  = 2000;

    logic                    aclk;
    logic                    memresetn;
    logic                    cmpl_valid;
    logic                    cmpl_ready;
    readout_pkg::link_idx_t  cmpl_link;
    readout_pkg::cmpl_word_t cmpl_data;
    logic                    hdr_valid;
    logic                    hdr_ready;
    readout_pkg::hdr_word_t  hdr_data;
    logic                    ctrl_valid;
    logic                    ctrl_ready;
    readout_pkg::ctrl_word_t ctrl_data;
    logic                    mem_rd;
    mem_pkg::mem_addr_t      mem_addr;
    logic                    mem_rvalid;
    mem_pkg::mem_data_t      mem_rdata;
    logic                    data_valid;
    logic                    data_ready;
    logic                    data_last;
    mem_pkg::mem_data_t      data_data;
    logic                    any_err;

    // one row per event
    readout_pkg::hdr_word_t  hdr_tab  [NUM_ROWS];
    readout_pkg::cmpl_word_t cmpl_tab [NUM_ROWS][`READOUT_NUM_LINKS];
    readout_pkg::ctrl_word_t ctrl_tab [NUM_ROWS];
    bit                      err_tab  [NUM_ROWS];
    bit                      rst_tab  [NUM_ROWS];

    int mismatch_count = 0;
    int failure_count  = 0;
    int cmpl_count     = 0;
    int hdr_count      = 0;
    int ctrl_idx       = 0;
    int data_evt       = 0;
    int data_word      = 0;

    logic               rd_seen;
    mem_pkg::mem_addr_t rd_addr;
    mem_pkg::mem_addr_t exp_addr;

    event_readout_top event_readout_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // memory contents: address above its own inverse
    function automatic mem_pkg::mem_data_t mem_word(input mem_pkg::mem_addr_t addr);
        return {2'b00, addr, ~addr};
    endfunction

    task automatic check_ctrl(input readout_pkg::ctrl_word_t exp,
                              input readout_pkg::ctrl_word_t act);
        if (act !== exp) begin
            $display("Error at %0t: ctrl_data expected %h, got %h", $time, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_data(input mem_pkg::mem_data_t exp, input mem_pkg::mem_data_t act);
        if (act !== exp) begin
            $display("Error at %0t: data_data expected %h, got %h", $time, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_last(input bit exp, input bit act);
        if (act !== exp) begin
            $display("Error at %0t: data_last expected %b, got %b", $time, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_err(input bit exp, input bit act);
        if (act !== exp) begin
            $display("Error at %0t: any_err expected %b, got %b", $time, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic set_row(input int r, input logic [23:0] hdr,
                           input logic [31:0] c0, input logic [31:0] c1,
                           input logic [31:0] c2, input logic [31:0] c3,
                           input logic [31:0] ctrl, input bit err, input bit rst);
        hdr_tab[r]     = hdr;
        cmpl_tab[r][0] = c0;
        cmpl_tab[r][1] = c1;
        cmpl_tab[r][2] = c2;
        cmpl_tab[r][3] = c3;
        ctrl_tab[r]    = ctrl;
        err_tab[r]     = err;
        rst_tab[r]     = rst;
    endtask

    // ctrl byte count is 8 words of 8 bytes
    task automatic load_table();
        set_row(0, {3'b0, 13'h00A5, 8'h00}, 32'h1000_0000, 32'h1001_0000, 32'h1002_0000,
                32'h1003_0000, {12'h0A5, 1'b0, 19'd64}, 1'b0, 1'b0);
        set_row(1, {3'b0, 13'h1F3C, 8'h00}, 32'h2000_0000, 32'h2001_0000, 32'h2002_0000,
                32'h2003_0000, {12'hF3C, 1'b0, 19'd64}, 1'b0, 1'b0);
        // link 1 reports a failure
        set_row(2, {3'b0, 13'h0777, 8'h00}, 32'h3000_0000, 32'h3001_0040, 32'h3002_0000,
                32'h3003_0000, {12'h777, 1'b0, 19'd64}, 1'b1, 1'b0);
        set_row(3, {3'b0, 13'h1001, 8'h00}, 32'h4000_0000, 32'h4001_0000, 32'h4002_0000,
                32'h4003_0000, {12'h001, 1'b0, 19'd64}, 1'b1, 1'b0);
        set_row(4, {3'b0, 13'h0ABC, 8'h00}, 32'h5000_0000, 32'h5001_0000, 32'h5002_0000,
                32'h5003_0000, {12'hABC, 1'b0, 19'd64}, 1'b0, 1'b1);
        // header error after a fresh reset
        set_row(5, {3'b0, 13'h1234, 8'h10}, 32'h6000_0000, 32'h6001_0000, 32'h6002_0000,
                32'h6003_0000, {12'h234, 1'b0, 19'd64}, 1'b1, 1'b0);
        set_row(6, {3'b0, 13'h0F0F, 8'h00}, 32'h7000_0000, 32'h7001_0000, 32'h7002_0000,
                32'h7003_0000, {12'hF0F, 1'b0, 19'd64}, 1'b1, 1'b0);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #5;
        end
    endtask

    task automatic drive_ready_noise();
        forever begin
            @(posedge aclk);
            #5;
            ctrl_ready = ($urandom % 4) != 0;
            data_ready = ($urandom % 3) != 0;
        end
    endtask

    task automatic send_cmpl(input readout_pkg::link_idx_t link,
                             input readout_pkg::cmpl_word_t word);
        int  cyc;
        bit  taken;
        cmpl_valid = 1'b1;
        cmpl_link  = link;
        cmpl_data  = word;
        cyc = 0;
        @(negedge aclk);
        while (!cmpl_ready && cyc < TIMEOUT) begin
            @(negedge aclk);
            cyc++;
        end
        taken = cmpl_ready;
        @(posedge aclk);
        #5;
        cmpl_valid = 1'b0;
        if (!taken) begin
            $display("timeout: completion for link %0d never accepted", link);
            failure_count++;
        end
    endtask

    // each event's links go out in a random order
    task automatic send_completions(input int first, input int last);
        int order [`READOUT_NUM_LINKS];
        int r;
        int i;
        int j;
        int tmp;
        for (r = first; r <= last; r++) begin
            for (i = 0; i < `READOUT_NUM_LINKS; i++) order[i] = i;
            for (i = `READOUT_NUM_LINKS - 1; i > 0; i--) begin
                j = $urandom % (i + 1);
                tmp = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            for (i = 0; i < `READOUT_NUM_LINKS; i++) begin
                wait_cycles($urandom % 3);
                send_cmpl(readout_pkg::link_idx_t'(order[i]), cmpl_tab[r][order[i]]);
            end
        end
    endtask

    task automatic send_headers(input int first, input int last);
        int r;
        int cyc;
        bit taken;
        for (r = first; r <= last; r++) begin
            wait_cycles(1 + $urandom % 12);
            hdr_valid = 1'b1;
            hdr_data  = hdr_tab[r];
            cyc = 0;
            @(negedge aclk);
            while (!hdr_ready && cyc < TIMEOUT) begin
                @(negedge aclk);
                cyc++;
            end
            taken = hdr_ready;
            @(posedge aclk);
            #5;
            hdr_valid = 1'b0;
            if (!taken) begin
                $display("timeout: header of event %0d never accepted", r);
                failure_count++;
            end else begin
                // errors of this event are visible, the next event's are not yet
                @(posedge aclk);
                @(negedge aclk);
                check_err(err_tab[r], any_err);
                @(posedge aclk);
                #5;
            end
        end
    endtask

    task automatic wait_events_done(input int target);
        int cyc;
        cyc = 0;
        while ((data_evt < target || ctrl_idx < target) && cyc < TIMEOUT) begin
            @(posedge aclk);
            cyc++;
        end
        if (data_evt < target || ctrl_idx < target) begin
            $display("timeout: only %0d data bursts and %0d control words of %0d events",
                     data_evt, ctrl_idx, target);
            failure_count++;
        end
        @(posedge aclk);
        #5;
    endtask

    task automatic apply_reset();
        memresetn = 1'b0;
        repeat (3) @(posedge aclk);
        #5;
        memresetn = 1'b1;
        check_err(1'b0, any_err);
    endtask

    // memory answers one cycle after each strobe
    always @(negedge aclk) begin
        rd_seen = mem_rd;
        rd_addr = mem_addr;
    end

    always @(posedge aclk) begin
        #5;
        mem_rvalid = (rd_seen === 1'b1);
        mem_rdata  = mem_word(rd_addr);
    end

    // completions may only run one event ahead of the accepted headers
    always @(negedge aclk) begin
        if (cmpl_valid && cmpl_ready) begin
            if (cmpl_count >= `READOUT_NUM_LINKS * (hdr_count + 1)) begin
                $display("completion accepted at %0t before its event's header", $time);
                failure_count++;
            end
            cmpl_count++;
        end
        if (hdr_valid && hdr_ready) begin
            if (cmpl_count != `READOUT_NUM_LINKS * (hdr_count + 1)) begin
                $display("header %0d accepted at %0t without all link completions",
                         hdr_count, $time);
                failure_count++;
            end
            hdr_count++;
        end
    end

    always @(negedge aclk) begin
        if (ctrl_valid && ctrl_ready) begin
            if (ctrl_idx >= NUM_ROWS) begin
                $display("unexpected extra control word at %0t", $time);
                failure_count++;
            end else begin
                check_ctrl(ctrl_tab[ctrl_idx], ctrl_data);
                ctrl_idx++;
            end
        end
    end

    always @(negedge aclk) begin
        if (data_valid && data_ready) begin
            if (data_evt >= NUM_ROWS) begin
                $display("unexpected extra data word at %0t", $time);
                failure_count++;
            end else begin
                exp_addr = {hdr_tab[data_evt].upper_addr, `READOUT_START_OFFSET};
                exp_addr = exp_addr + mem_pkg::mem_addr_t'(data_word);
                check_data(mem_word(exp_addr), data_data);
                check_last(data_word == `READOUT_BURST_WORDS - 1, data_last);
                if (data_word == `READOUT_BURST_WORDS - 1) begin
                    data_word = 0;
                    data_evt++;
                end else begin
                    data_word++;
                end
            end
        end
    end

    initial begin
        int first;
        int row;
        void'($urandom(82));
        memresetn  = 1'b0;
        cmpl_valid = 1'b0;
        cmpl_link  = '0;
        cmpl_data  = '0;
        hdr_valid  = 1'b0;
        hdr_data   = '0;
        ctrl_ready = 1'b0;
        data_ready = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        load_table();
        fork
            drive_ready_noise();
        join_none
        repeat (3) @(posedge aclk);
        #5;
        memresetn = 1'b1;
        // rows between resets run as one overlapping stream
        first = 0;
        for (row = 0; row < NUM_ROWS; row++) begin
            if (row == NUM_ROWS - 1 || rst_tab[row + 1]) begin
                fork
                    send_completions(first, row);
                    send_headers(first, row);
                join
                wait_events_done(row + 1);
                if (row < NUM_ROWS - 1) apply_reset();
                first = row + 1;
            end
        end
        $display("closing report: %0d value mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/readout_pkg.sv
hdl/mem_pkg.sv
hdl/readout_if.sv
hdl/completion_router.sv
hdl/completion_lane.sv
hdl/readout_sequencer.sv
hdl/event_reader.sv
hdl/event_readout_top.sv
tb/event_readout_tb.sv

// ==== Bender.yml ====
package:
  name: event_readout

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/readout_pkg.sv
      - hdl/mem_pkg.sv
      - hdl/readout_if.sv
      - hdl/completion_router.sv
      - hdl/completion_lane.sv
      - hdl/readout_sequencer.sv
      - hdl/event_reader.sv
      - hdl/event_readout_top.sv
  - target: test
    files:
      - tb/event_readout_tb.sv
